// File: sim/organ_vectors.txt
// Columns: command, argument, expected value; all hex, one command per line
// 1 note: code, {name, half-period}   2 up, 3 down: ticks held, count shown
// 4 speed reset: cycles held, count shown   5 enable: sw[0], sample   0 end
5 1 7F
1 0 446F0000BAB9 // Do
1 1 52650000A65D // Re
1 3 4D6900009430 // Mi
1 2 466100008BE9 // Fa
1 6 536F00007CB8 // So
1 4 4C6100006EF9 // La
1 5 5369000062F1 // Si
1 7 443200005D5D // D2
5 0 0
2 3 31FF // 12499 + 300
3 1 319B // 12799 - 100
3 5 2FA7 // 12699 - 500
4 4 30D3 // Back to default
2 2 319B
4 4 30D3
0 0 0

// File: sources.f
design/organ_pkg.sv
design/note_select.sv
design/key_rate_limiter.sv
design/tone_generator.sv
design/sample_rate_control.sv
design/hex_display.sv
design/organ_top.sv
sim/tb_organ.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_organ; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_organ \
  -f sources.f -o tb_organ || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_organ > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"

// File: sim/tb_organ.sv
// Testbench for organ_top with short rate and refresh intervals
// Commands and expected values come from sim/organ_vectors.txt, run from the project root
// Stops at the first mismatch; a cycle limit guards against a hung run
`timescale 1ns/1ps

module tb_organ;

  localparam int RATE_CYCLES    = 50;       // Key step interval
  localparam int REFRESH_CYCLES = 100;      // Display refresh interval
  localparam int MAX_VECS       = 20;       // Command lines the file may hold
  localparam int STEP_LIMIT     = 150_000;  // Worst step, about 3 half waves of Do
  localparam int unsigned TIMEOUT_CYCLES = MAX_VECS * STEP_LIMIT;  // About 3,000,000

  logic            CLK_50M;
  logic            rst;
  logic [3:0]      sw;            // sw[0] audio on, sw[3:1] note
  logic [2:0]      key_n;         // Up, down, speed reset; active low
  logic [7:0]      audio_sample;
  logic [15:0]     note_name;
  logic [5:0][6:0] hex_seg;       // Digit 0 least significant

  logic [47:0] vec_mem [0:63];  // Three words per command
  int unsigned cycle_cnt = 0;

  organ_top #(
    .RATE_CYCLES    (RATE_CYCLES),
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) dut_i (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sw           (sw),
    .key_n        (key_n),
    .audio_sample (audio_sample),
    .note_name    (note_name),
    .hex_seg      (hex_seg)
  );

  // ====================
  // Clock and limit
  // ====================
  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;  // 20 ns period
  end

  always @(posedge CLK_50M) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run still busy after %0d cycles", cycle_cnt));
    end
  end

  // ====================
  // Helpers
  // ====================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string sig, input logic [47:0] got, input logic [47:0] exp);
    assert (got === exp)
      else abort_run($sformatf("Fail at time %0t: %s got %0h expected %0h",
                               $time, sig, got, exp));
  endtask

  // Active-low patterns back to nibbles; bit 4 flags a bad pattern
  function automatic logic [4:0] seg_to_nibble(input logic [6:0] seg);
    case (seg)
      7'h40: return 5'h0;
      7'h79: return 5'h1;
      7'h24: return 5'h2;
      7'h30: return 5'h3;
      7'h19: return 5'h4;
      7'h12: return 5'h5;
      7'h02: return 5'h6;
      7'h78: return 5'h7;
      7'h00: return 5'h8;
      7'h10: return 5'h9;
      7'h08: return 5'hA;
      7'h03: return 5'hB;  // Lower case b
      7'h46: return 5'hC;
      7'h21: return 5'hD;  // Lower case d
      7'h06: return 5'hE;
      7'h0E: return 5'hF;
      default: return 5'h10;
    endcase
  endfunction

  task automatic check_display(input logic [23:0] exp);
    logic [23:0] shown;
    logic [4:0]  nib;
    int          d;
    @(negedge CLK_50M);  // Segments settled
    for (d = 0; d < 6; d++) begin
      nib = seg_to_nibble(hex_seg[d]);
      assert (!nib[4])
        else abort_run($sformatf("Digit %0d shows pattern %h, which is not a hex digit",
                                 d, hex_seg[d]));
      shown[4*d +: 4] = nib[3:0];
    end
    check_value("hex_seg", 48'(shown), 48'(exp));
  endtask

  // Next change of the sample, which must swing between 7F and 80
  task automatic wait_sample_edge(output int unsigned edge_cycle);
    logic [7:0] prev;
    @(negedge CLK_50M);
    prev = audio_sample;
    do begin
      @(negedge CLK_50M);
    end while (audio_sample == prev);
    edge_cycle = cycle_cnt;
    assert ((audio_sample == 8'h7F) || (audio_sample == 8'h80))
      else abort_run($sformatf("Fail at time %0t: audio_sample got %0h expected 7f or 80",
                               $time, audio_sample));
  endtask

  task automatic run_note(input logic [2:0] code, input logic [47:0] exp);
    int unsigned first_edge;
    int unsigned second_edge;
    @(posedge CLK_50M);
    sw[3:1] <= code;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_value("note_name", 48'(note_name), 48'(exp[47:32]));
    wait_sample_edge(first_edge);  // Restart edge is already past here
    wait_sample_edge(second_edge);
    check_value("half_period", 48'(second_edge - first_edge), 48'(exp[31:0]));
  endtask

  task automatic set_enable(input logic on, input logic [7:0] exp);
    @(posedge CLK_50M);
    sw[0] <= on;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    if (on) begin
      // Wave phase unknown, either level is fine
      assert ((audio_sample == exp) || (audio_sample == ~exp))
        else abort_run($sformatf("Fail at time %0t: audio_sample got %0h expected %0h or %0h",
                                 $time, audio_sample, exp, ~exp));
    end else begin
      check_value("audio_sample", 48'(audio_sample), 48'(exp));
    end
  endtask

  task automatic hold_key(input logic [2:0] mask, input int unsigned cycles);
    @(posedge CLK_50M);
    key_n <= ~mask;  // Pressed keys low
    repeat (cycles) @(posedge CLK_50M);
    key_n <= 3'b111;
  endtask

  // ====================
  // Vector sequence
  // ====================
  initial begin
    logic [5:0]  addr;
    logic [3:0]  cmd;
    int unsigned arg;
    logic [47:0] exp;
    logic        done;
    int          vec_num;
    $readmemh("sim/organ_vectors.txt", vec_mem);
    rst   <= 1'b1;
    sw    <= 4'b0000;
    key_n <= 3'b111;  // No key pressed
    repeat (5) @(posedge CLK_50M);
    rst <= 1'b0;
    check_display(24'h0030D3);  // Default count straight after reset
    check_value("audio_sample", 48'(audio_sample), 48'h0);
    addr    = 6'd0;
    done    = 1'b0;
    vec_num = 0;
    while (!done && (vec_num < MAX_VECS)) begin
      cmd = vec_mem[addr][3:0];
      arg = vec_mem[addr + 6'd1][31:0];
      exp = vec_mem[addr + 6'd2];
      case (cmd)
        4'h0: done = 1'b1;
        4'h1: run_note(arg[2:0], exp);
        4'h2: begin
          hold_key(3'b001, arg * RATE_CYCLES);  // N ticks of up
          repeat (RATE_CYCLES + REFRESH_CYCLES) @(posedge CLK_50M);
          check_display(exp[23:0]);
        end
        4'h3: begin
          hold_key(3'b010, arg * RATE_CYCLES);
          repeat (RATE_CYCLES + REFRESH_CYCLES) @(posedge CLK_50M);
          check_display(exp[23:0]);
        end
        4'h4: begin
          hold_key(3'b100, arg);  // Level key, cycles not ticks
          repeat (REFRESH_CYCLES + 4) @(posedge CLK_50M);
          check_display(exp[23:0]);
        end
        4'h5: set_enable(arg[0], exp[7:0]);
        default: abort_run($sformatf("Unknown command %h in vector %0d", cmd, vec_num));
      endcase
      addr = addr + 6'd3;
      vec_num++;
    end
    $display("Test passed");
    $finish;
  end

endmodule

// File: design/organ_top.sv
// Organ top level, single CLK_50M domain
// sw[0] enables audio, sw[3:1] selects the note
// key_n[0..2] are speed up, speed down and speed reset, active low
// Timing parameters default to real board rates
`timescale 1ns/1ps

module organ_top #(
  parameter int RATE_CYCLES    = 5_000_000,   // Key step interval
  parameter int REFRESH_CYCLES = 25_000_000   // Display refresh interval
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic [3:0]            sw,
  input  logic [2:0]            key_n,
  output organ_pkg::sample_t    audio_sample,
  output organ_pkg::note_name_t note_name,
  output organ_pkg::hex_seg_t   hex_seg
);

  import organ_pkg::*;

  // ====================
  // Internal wires
  // ====================
  note_info_t   note;         // Pitch and name of current note
  key_events_t  events;       // Speed key events
  scope_count_t scope_count;  // Default plus offset

  assign note_name = note.name;  // ASCII pair straight out

  // Input side
  note_select note_select_i (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .note_sw (sw[3:1]),
    .note    (note)
  );

  key_rate_limiter #(
    .RATE_CYCLES (RATE_CYCLES)
  ) key_rate_limiter_i (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .key_n   (key_n),
    .events  (events)
  );

  // Processing
  tone_generator tone_generator_i (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .enable       (sw[0]),
    .note         (note),
    .audio_sample (audio_sample)
  );

  sample_rate_control sample_rate_control_i (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .events      (events),
    .scope_count (scope_count)
  );

  // Output side
  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) hex_display_i (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .scope_count (scope_count),
    .hex_seg     (hex_seg)
  );

endmodule

// File: design/hex_display.sv
// Six-digit hex display of the sampling count
// The shown value is a snapshot, refreshed every REFRESH_CYCLES,
// so a new count can take up to REFRESH_CYCLES to appear
`timescale 1ns/1ps

module hex_display #(
  parameter int REFRESH_CYCLES = 25_000_000  // 2 Hz at 50 MHz
) (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  organ_pkg::scope_count_t scope_count,
  output organ_pkg::hex_seg_t     hex_seg      // Digit 0 least significant
);

  import organ_pkg::*;

  localparam int REFRESH_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;

  // ====================
  // Refresh tick
  // ====================
  logic [REFRESH_W-1:0] refresh_cnt;
  logic                 refresh_tick;  // One cycle per refresh

  assign refresh_tick = (refresh_cnt == REFRESH_W'(REFRESH_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      refresh_cnt <= '0;
    end else if (refresh_tick) begin
      refresh_cnt <= '0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // ====================
  // Display latch
  // ====================
  scope_count_t shown_q;  // Value on the digits

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      shown_q <= DEFAULT_SCOPE_COUNT;  // 0030D3 straight after reset
    end else if (refresh_tick) begin
      shown_q <= scope_count;
    end
  end

  // Nibble per digit through the segment table
  always_comb begin
    for (int i = 0; i < NUM_DIGITS; i++) begin
      hex_seg[i] = SEG_TABLE[shown_q[4*i +: 4]];
    end
  end

endmodule

// File: design/sample_rate_control.sv
// Speed offset and scope sampling count
// Offset has no saturation; users keep it within the 16-bit signed range
// Reset key wins over up and down in the same cycle
`timescale 1ns/1ps

module sample_rate_control (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  organ_pkg::key_events_t  events,
  output organ_pkg::scope_count_t scope_count
);

  import organ_pkg::*;

  localparam int EXT_W = $bits(scope_count_t) - $bits(speed_t);  // Sign bits to add

  // ====================
  // Speed offset
  // ====================
  speed_t speed_q;  // Signed, steps of SPEED_STEP

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      speed_q <= '0;
    end else if (events.reset) begin
      speed_q <= '0;  // Back to default rate
    end else if (events.up) begin
      speed_q <= speed_q + SPEED_STEP;
    end else if (events.down) begin
      speed_q <= speed_q - SPEED_STEP;
    end
  end

  // ====================
  // Sampling count
  // ====================
  // Default plus the sign-extended offset, one cycle after speed
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      scope_count <= DEFAULT_SCOPE_COUNT;
    end else begin
      scope_count <= DEFAULT_SCOPE_COUNT + {{EXT_W{speed_q[$bits(speed_t)-1]}}, speed_q};
    end
  end

  // Too many down events would wrap the count through zero
  count_positive_a: assert property (
    @(posedge CLK_50M) disable iff (rst)
      (scope_count != '0) && !scope_count[$bits(scope_count_t)-1]
  ) else $error("Sampling count no longer positive");

endmodule

// File: design/tone_generator.sv
// Square wave tone from a half-period count in CLK_50M cycles
// A new half-period restarts the wave low; no glitch filtering
// Sample is 7F/80 while enabled, 0 one cycle after enable drops
`timescale 1ns/1ps

module tone_generator (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  enable,        // sw[0]
  input  organ_pkg::note_info_t note,
  output organ_pkg::sample_t    audio_sample
);

  import organ_pkg::*;

  // ====================
  // Half-period counter
  // ====================
  half_period_t period_q;     // Last half-period seen
  half_period_t cnt_q;        // Cycles into this half wave
  logic         wave_q;       // Square wave
  logic         note_change;  // New note this cycle

  assign note_change = (note.half_period != period_q);

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      period_q <= '0;  // Forces a clean restart after reset
      cnt_q    <= '0;
      wave_q   <= 1'b0;
    end else begin
      period_q <= note.half_period;
      if (note_change) begin
        cnt_q  <= '0;    // Restart low on a new pitch
        wave_q <= 1'b0;
      end else if (cnt_q >= note.half_period - 1'b1) begin
        cnt_q  <= '0;
        wave_q <= ~wave_q;  // Half wave done
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // ====================
  // Audio sample
  // ====================
  // Low wave gives 7F, high wave gives 80
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      audio_sample <= '0;
    end else if (enable) begin
      audio_sample <= sample_t'({wave_q, {($bits(sample_t) - 1){~wave_q}}});
    end else begin
      audio_sample <= '0;  // Muted
    end
  end

  // Table entries from note_select must give a real divider
  half_period_nonzero_a: assert property (
    @(posedge CLK_50M) disable iff (rst)
      note.half_period != '0
  ) else $error("Zero half-period from note table");

endmodule

// File: design/key_rate_limiter.sv
// Key synchroniser and rate limiter, all in the CLK_50M domain
// Up and down give one pulse per RATE_CYCLES while held, so latency
// varies up to RATE_CYCLES; reset passes as a synchronised level
`timescale 1ns/1ps

module key_rate_limiter #(
  parameter int RATE_CYCLES = 5_000_000  // 10 events per second at 50 MHz
) (
  input  logic                   CLK_50M,
  input  logic                   rst,
  input  logic [2:0]             key_n,   // Active low keys
  output organ_pkg::key_events_t events
);

  import organ_pkg::*;

  localparam int RATE_W = (RATE_CYCLES > 1) ? $clog2(RATE_CYCLES) : 1;

  // ====================
  // Synchroniser
  // ====================
  logic [2:0] key_meta;  // First stage, may go metastable
  logic [2:0] key_sync;  // Second stage, safe to use

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      key_meta <= '0;
      key_sync <= '0;
    end else begin
      key_meta <= ~key_n;  // Pressed = 1 from here on
      key_sync <= key_meta;
    end
  end

  // ====================
  // Rate interval
  // ====================
  logic [RATE_W-1:0] rate_cnt;   // Free running
  logic              rate_tick;  // One cycle per interval

  assign rate_tick = (rate_cnt == RATE_W'(RATE_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      rate_cnt <= '0;
    end else if (rate_tick) begin
      rate_cnt <= '0;  // Wrap at the end of the interval
    end else begin
      rate_cnt <= rate_cnt + 1'b1;
    end
  end

  // Held keys sampled on the tick only
  logic up_q;
  logic down_q;

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      up_q   <= 1'b0;
      down_q <= 1'b0;
    end else begin
      up_q   <= rate_tick & key_sync[0];  // Key 0 speeds up
      down_q <= rate_tick & key_sync[1];  // Key 1 slows down
    end
  end

  // Key 2 is not rate limited
  assign events = '{up: up_q, down: down_q, reset: key_sync[2]};

  // Held keys give separate pulses, never a run of them
  step_rate_limited_a: assert property (
    @(posedge CLK_50M) disable iff (rst)
      (events.up || events.down) |=> !(events.up || events.down)
  ) else $error("Step pulses on back-to-back cycles");

endmodule

// File: design/note_select.sv
// Note switch input stage
// Switches are assumed static or slow; they are registered once, not debounced
// Every code maps to a note, so no invalid selection exists
`timescale 1ns/1ps

module note_select (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  organ_pkg::note_code_t note_sw,  // sw[3:1]
  output organ_pkg::note_info_t note      // Half-period and name
);

  import organ_pkg::*;

  // ====================
  // Switch register
  // ====================
  note_code_t code_q;  // Registered switch code

  // One flop stage; note follows sw one cycle later
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      code_q <= '0;  // Do after reset
    end else begin
      code_q <= note_sw;
    end
  end

  // ====================
  // Table lookup
  // ====================
  // Pure table read from the registered code
  // The Gray order lives in NOTE_TABLE itself:
  //   000 Do, 001 Re, 011 Mi, 010 Fa,
  //   110 So, 100 La, 101 Si, 111 D2
  always_comb begin
    note = NOTE_TABLE[code_q];
  end

endmodule

// File: design/organ_pkg.sv
// Shared types and tables for the organ on a 50 MHz board
// Half-periods are in CLK_50M cycles, note names are two ASCII chars
// Segment patterns are active low, bit 0 = a up to bit 6 = g
package organ_pkg;

  // ====================
  // Widths
  // ====================
  typedef logic [31:0]        half_period_t;  // CLK_50M cycles per half wave
  typedef logic [2:0]         note_code_t;    // Note switch code, Gray ordered
  typedef logic [15:0]        note_name_t;    // Two ASCII chars
  typedef logic signed [7:0]  sample_t;       // Signed audio sample
  typedef logic signed [15:0] speed_t;        // Signed speed offset
  typedef logic [23:0]        scope_count_t;  // Sampling count, six hex digits
  typedef logic [6:0]         seg_t;          // One seven-segment digit

  // Display constants
  localparam int NUM_DIGITS = 6;

  // All six digits as one bundle, digit 0 least significant
  typedef seg_t [NUM_DIGITS-1:0] hex_seg_t;

  // ====================
  // Structs
  // ====================
  typedef struct packed {
    half_period_t half_period;  // Tone divider
    note_name_t   name;         // For example "Do"
  } note_info_t;

  typedef struct packed {
    logic up;     // One-cycle pulse, rate limited
    logic down;   // One-cycle pulse, rate limited
    logic reset;  // Level, not rate limited
  } key_events_t;

  // ====================
  // Tables
  // ====================
  // Indexed by switch code; codes run in Gray order up the scale
  localparam note_info_t NOTE_TABLE [8] = '{
    '{half_period: 32'h0000_BAB9, name: "Do"},  // 000, 523 Hz
    '{half_period: 32'h0000_A65D, name: "Re"},  // 001, 587 Hz
    '{half_period: 32'h0000_8BE9, name: "Fa"},  // 010, 698 Hz
    '{half_period: 32'h0000_9430, name: "Mi"},  // 011, 659 Hz
    '{half_period: 32'h0000_6EF9, name: "La"},  // 100, 880 Hz
    '{half_period: 32'h0000_62F1, name: "Si"},  // 101, 987 Hz
    '{half_period: 32'h0000_7CB8, name: "So"},  // 110, 783 Hz
    '{half_period: 32'h0000_5D5D, name: "D2"}   // 111, high Do
  };

  // Hex digit patterns 0..F, active low
  localparam seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,  // 0 1 2 3
    7'h19, 7'h12, 7'h02, 7'h78,  // 4 5 6 7
    7'h00, 7'h10, 7'h08, 7'h03,  // 8 9 A b
    7'h46, 7'h21, 7'h06, 7'h0E   // C d E F
  };

  // Scope sampling defaults
  localparam scope_count_t DEFAULT_SCOPE_COUNT = 24'd12499;  // About 2 kHz
  localparam speed_t       SPEED_STEP          = 16'sd100;   // Per key event

endpackage
